// ==== common/cpu_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types of the pipelined cpu: opcodes, alu ops,
// stage register structs and the host port address map
////////////////////////////////////////////////////////////
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT                     // signed compare
    } alu_op_t;

    typedef struct packed {
        alu_op_t  alu_op;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;              // already sign extended
        logic     use_imm;
        reg_idx_t dest;
        logic     reg_we;
        logic     mem_read;
        logic     mem_write;
    } dec_ex_t;

    typedef struct packed {
        word_t    result;           // alu result or memory address
        word_t    store_data;
        reg_idx_t dest;
        logic     reg_we;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic        imem_we;
        logic        dmem_we;
        logic [11:0] addr;          // word index from paddr[13:2]
        word_t       wdata;
    } host_req_t;

    // regions in paddr[15:14]
    localparam logic [1:0] HOST_CTRL = 2'd0;
    localparam logic [1:0] HOST_IMEM = 2'd1;
    localparam logic [1:0] HOST_DMEM = 2'd2;
    localparam logic [1:0] HOST_REGS = 2'd3;

endpackage

// ==== cpu_system.f ====
+incdir+dv
common/cpu_pkg.sv
decode/reg_file.sv
decode/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/instr_fetch.sv
verilog/apb_host_port.sv
verilog/cpu_system.sv
dv/cpu_system_tb.sv

// ==== decode/decode_stage.sv ====
////////////////////////////////////////////////////////////
// decode stage: control decode, operand select with memory
// forwarding, beq resolution and the decode/execute register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  logic      run,
    input  logic      stall,
    input  word_t     fd_instr,
    input  word_t     fd_pc,
    input  logic      fwd_rs,
    input  logic      fwd_rt,
    input  word_t     mem_fwd,
    input  wb_t       wb,
    input  host_req_t host_req,
    output word_t     reg_rdata,
    output reg_idx_t  rs_idx,
    output reg_idx_t  rt_idx,
    output logic      uses_rs,
    output logic      uses_rt,
    output dec_ex_t   dx,
    output logic      branch_taken,
    output word_t     branch_target
);
    opcode_t  op;
    funct_t   fn;
    reg_idx_t rd_idx;
    word_t    imm;
    word_t    rs_reg;
    word_t    rt_reg;
    word_t    rs_op;
    word_t    rt_op;
    logic     is_beq;
    dec_ex_t  dx_next;

    assign op     = opcode_t'(fd_instr[31:26]);
    assign fn     = funct_t'(fd_instr[5:0]);
    assign rs_idx = fd_instr[25:21];
    assign rt_idx = fd_instr[20:16];
    assign rd_idx = fd_instr[15:11];
    assign imm    = {{16{fd_instr[15]}}, fd_instr[15:0]};

    reg_file u_reg_file (
        .SYS_clk  (SYS_clk),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_val   (rs_reg),
        .rt_val   (rt_reg),
        .wb       (wb),
        .host_idx (host_req.addr[4:0]),
        .host_val (reg_rdata)
    );

    assign rs_op = fwd_rs ? mem_fwd : rs_reg;
    assign rt_op = fwd_rt ? mem_fwd : rt_reg;

    always_comb
    begin
        dx_next        = '0;            // unknown opcode falls out as a bubble
        dx_next.rs_val = rs_op;
        dx_next.rt_val = rt_op;
        dx_next.imm    = imm;
        dx_next.dest   = rt_idx;        // i-type writes rt
        uses_rs        = 1'b0;
        uses_rt        = 1'b0;
        is_beq         = 1'b0;
        case (op)
            OP_RTYPE:
            begin
                dx_next.dest   = rd_idx;
                dx_next.reg_we = 1'b1;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                case (fn)
                    FN_ADD:  dx_next.alu_op = ALU_ADD;
                    FN_SUB:  dx_next.alu_op = ALU_SUB;
                    FN_AND:  dx_next.alu_op = ALU_AND;
                    FN_OR:   dx_next.alu_op = ALU_OR;
                    FN_SLT:  dx_next.alu_op = ALU_SLT;
                    default:
                    begin
                        dx_next.reg_we = 1'b0;  // unsupported funct, nop
                        uses_rs        = 1'b0;
                        uses_rt        = 1'b0;
                    end
                endcase
            end
            OP_ADDI:
            begin
                dx_next.use_imm = 1'b1;
                dx_next.reg_we  = 1'b1;
                uses_rs         = 1'b1;
            end
            OP_LW:
            begin
                dx_next.use_imm  = 1'b1;
                dx_next.reg_we   = 1'b1;
                dx_next.mem_read = 1'b1;
                uses_rs          = 1'b1;
            end
            OP_SW:
            begin
                dx_next.use_imm   = 1'b1;
                dx_next.mem_write = 1'b1;
                uses_rs           = 1'b1;
                uses_rt           = 1'b1;   // store data
            end
            OP_BEQ:
            begin
                is_beq  = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            default:
            begin
                is_beq = 1'b0;
            end
        endcase
    end

    // beq resolves here, so operands must already be final
    assign branch_taken  = run && !stall && is_beq && (rs_op == rt_op);
    assign branch_target = fd_pc + 32'd4 + {imm[29:0], 2'b00};

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !run || stall)
        begin
            dx.reg_we    <= 1'b0;       // bubble into execute
            dx.mem_read  <= 1'b0;
            dx.mem_write <= 1'b0;
        end
        else
            dx <= dx_next;
    end

endmodule

// ==== decode/reg_file.sv ====
////////////////////////////////////////////////////////////
// 32 x 32 register file, two read ports plus a host port
// reads see the word being written back in the same cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_file
    import cpu_pkg::*;
(
    input  logic     SYS_clk,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_val,
    output word_t    rt_val,
    input  wb_t      wb,
    input  reg_idx_t host_idx,
    output word_t    host_val
);
    word_t regs [32];

    function automatic word_t rd_port(reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wb.we && wb.dest == idx)
            return wb.data;             // write-through
        return regs[idx];
    endfunction

    always_comb
    begin
        rs_val   = rd_port(rs_idx);
        rt_val   = rd_port(rt_idx);
        host_val = rd_port(host_idx);
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wb.we && wb.dest != '0)
            regs[wb.dest] <= wb.data;
    end

    a_r0_stays_zero: assert property (
        @(posedge SYS_clk) (wb.we && wb.dest == '0) |=> $stable(regs[0])
    ) else $error("write to r0 changed its contents");

endmodule

// ==== dv/isa_model.svh ====
////////////////////////////////////////////////////////////
// architectural model and random program generator,
// included in the body of the cpu testbench module
////////////////////////////////////////////////////////////
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int PROG_LEN = 24;

word_t prog  [PROG_LEN];
word_t mreg  [8];                       // r0..r7, r0 never written
word_t mdmem [16];                      // data words 0..15

function automatic word_t enc_rtype(funct_t fn, int rs, int rt, int rd);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
endfunction

function automatic word_t enc_itype(opcode_t op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic int rand_reg();
    return 1 + int'($urandom_range(6, 0));
endfunction

// kind 0 alu only, kind 1 adds lw/sw, kind 2 adds beq
function automatic void gen_program(int kind);
    funct_t fns [5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
    int     i;
    int     pick;
    int     room;
    int     rs;
    int     load_dest;
    load_dest = 0;
    for (i = 0; i < PROG_LEN - 1; i++)
    begin
        pick      = int'($urandom_range(9, 0));
        room      = PROG_LEN - 2 - i;   // a beq must land at or before the self-loop
        rs        = (load_dest != 0) ? load_dest : rand_reg();   // load then use
        load_dest = 0;
        if (kind == 2 && pick >= 7 && room > 0)
            prog[i] = enc_itype(OP_BEQ, rs, (pick == 9) ? rs : rand_reg(),
                                int'($urandom_range((room < 3) ? room : 3, 1)));
        else if (kind == 1 && pick >= 7)
        begin
            load_dest = rand_reg();
            prog[i]   = enc_itype(OP_LW, 0, load_dest, 4 * int'($urandom_range(15, 0)));
        end
        else if (kind == 1 && pick >= 5)
            prog[i] = enc_itype(OP_SW, 0, rand_reg(), 4 * int'($urandom_range(15, 0)));
        else if (pick < 3)
            prog[i] = enc_itype(OP_ADDI, rs, rand_reg(), int'($urandom_range(65535, 0)));
        else
            prog[i] = enc_rtype(fns[$urandom_range(4, 0)], rs, rand_reg(), rand_reg());
    end
    prog[PROG_LEN-1] = enc_itype(OP_BEQ, 0, 0, -1);    // self-loop ends the program
endfunction

// runs prog until it reaches the closing self-loop, no delay slot
function automatic void run_model();
    int    pc;
    int    steps;
    word_t ins;
    word_t a;
    word_t b;
    word_t imm;
    word_t addr;
    word_t res;
    pc    = 0;
    steps = 0;
    while (pc < PROG_LEN - 1 && steps < 4 * PROG_LEN)
    begin
        ins   = prog[pc];
        a     = mreg[ins[23:21]];       // sources are r0..r7
        b     = mreg[ins[18:16]];
        imm   = {{16{ins[15]}}, ins[15:0]};
        addr  = a + imm;
        pc    = pc + 1;
        steps = steps + 1;
        case (ins[31:26])
            OP_RTYPE:
            begin
                case (ins[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: res = '0;
                endcase
                mreg[ins[13:11]] = res;
            end
            OP_ADDI: mreg[ins[18:16]] = addr;
            OP_LW:   mreg[ins[18:16]] = mdmem[addr[5:2]];
            OP_SW:   mdmem[addr[5:2]] = b;
            OP_BEQ:
            begin
                if (a == b)
                    pc = pc + int'(imm);
            end
            default: ;
        endcase
    end
endfunction

`endif

// ==== dv/cpu_system_tb.sv ====
////////////////////////////////////////////////////////////
// loads random programs into cpu_system over apb, runs them
// and compares registers and data memory with the isa model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_system_tb
    import cpu_pkg::*;
();
    logic        SYS_clk;
    logic        SYS_reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        pslverr;

    int cycle_count = 0;
    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;

    `include "isa_model.svh"

    localparam int N_PROGS     = 4;                 // programs per pipeline test
    localparam int APB_CYCLES  = 4;                 // one transfer plus margin
    localparam int RUN_CYCLES  = 3 * PROG_LEN + 20;
    localparam int PROG_CYCLES = (PROG_LEN + 2 * 16 + 7 + 2) * APB_CYCLES + RUN_CYCLES;
    localparam int T1_CYCLES   = (4 * 16 + 32) * APB_CYCLES;
    localparam int T2_CYCLES   = 16 * APB_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 + T1_CYCLES + T2_CYCLES + 3 * N_PROGS * PROG_CYCLES + 2000;

    cpu_system #(.IMEM_AW(8), .DMEM_AW(8)) UUT (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #2 SYS_clk = ~SYS_clk;
    end

    always @(posedge SYS_clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        test_checks++;
        assert (got === exp)
        else
        begin
            test_errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // one transfer that starts and ends 1 ns after a rising edge
    task automatic apb_xfer(input logic write, input logic [1:0] region, input int idx,
                            input word_t wdata, input logic exp_err, output word_t rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = {region, 12'(idx), 2'b00};
        pwdata  = wdata;
        @(posedge SYS_clk);
        #1;
        penable = 1'b1;
        @(posedge SYS_clk);
        #1;
        while (!pready)
        begin
            @(posedge SYS_clk);
            #1;
        end
        rdata = prdata;
        check_word("pslverr", 32'(pslverr), 32'(exp_err));
        @(posedge SYS_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [1:0] region, input int idx, input word_t data,
                             input logic exp_err);
        word_t unused;
        apb_xfer(1'b1, region, idx, data, exp_err, unused);
    endtask

    task automatic apb_read(input logic [1:0] region, input int idx, input logic exp_err,
                            output word_t data);
        apb_xfer(1'b0, region, idx, '0, exp_err, data);
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks   = 0;
        test_errors   = 0;
    endtask

    task automatic halted_access();
        int    k;
        int    imem_at [16];
        int    dmem_at [16];
        word_t imem_exp [16];
        word_t dmem_exp [16];
        word_t got;
        for (k = 0; k < 16; k++)
        begin
            imem_at[k]  = 16 * k + int'($urandom_range(15, 0));  // one word per block of 16
            dmem_at[k]  = 16 * k + int'($urandom_range(15, 0));
            imem_exp[k] = $urandom;
            dmem_exp[k] = $urandom;
            apb_write(HOST_IMEM, imem_at[k], imem_exp[k], 1'b0);
            apb_write(HOST_DMEM, dmem_at[k], dmem_exp[k], 1'b0);
        end
        for (k = 0; k < 16; k++)
        begin
            apb_read(HOST_IMEM, imem_at[k], 1'b0, got);
            check_word($sformatf("imem[%0d]", imem_at[k]), got, imem_exp[k]);
            apb_read(HOST_DMEM, dmem_at[k], 1'b0, got);
            check_word($sformatf("dmem[%0d]", dmem_at[k]), got, dmem_exp[k]);
        end
        for (k = 0; k < 32; k++)
        begin
            apb_read(HOST_REGS, k, 1'b0, got);
            check_word($sformatf("r%0d", k), got, '0);
        end
    endtask

    task automatic busy_access();
        word_t imem_keep;
        word_t dmem_keep;
        word_t got;
        imem_keep = $urandom;
        dmem_keep = $urandom;
        apb_write(HOST_IMEM, 0, enc_itype(OP_BEQ, 0, 0, -1), 1'b0);  // core spins at 0
        apb_write(HOST_IMEM, 9, imem_keep, 1'b0);
        apb_write(HOST_DMEM, 9, dmem_keep, 1'b0);
        apb_write(HOST_CTRL, 0, 32'd1, 1'b0);
        apb_read(HOST_CTRL, 0, 1'b0, got);
        check_word("run", got, 32'd1);
        apb_write(HOST_IMEM, 9, ~imem_keep, 1'b1);
        apb_write(HOST_DMEM, 9, ~dmem_keep, 1'b1);
        apb_write(HOST_REGS, 3, 32'h0000_dead, 1'b1);
        apb_read(HOST_IMEM, 9, 1'b1, got);
        check_word("prdata", got, '0);
        apb_read(HOST_DMEM, 9, 1'b1, got);
        check_word("prdata", got, '0);
        apb_read(HOST_REGS, 3, 1'b1, got);          // register reads blocked while running
        check_word("prdata", got, '0);
        apb_write(HOST_CTRL, 0, 32'd0, 1'b0);
        apb_write(HOST_REGS, 3, 32'h0000_beef, 1'b1);  // read only even when halted
        apb_read(HOST_IMEM, 9, 1'b0, got);
        check_word("imem[9]", got, imem_keep);
        apb_read(HOST_DMEM, 9, 1'b0, got);
        check_word("dmem[9]", got, dmem_keep);
        apb_read(HOST_REGS, 3, 1'b0, got);
        check_word("r3", got, mreg[3]);
    endtask

    task automatic run_program(input int kind);
        int    k;
        word_t got;
        gen_program(kind);
        if (kind == 1)
        begin
            for (k = 0; k < 16; k++)
            begin
                mdmem[k] = $urandom;
                apb_write(HOST_DMEM, k, mdmem[k], 1'b0);
            end
        end
        for (k = 0; k < PROG_LEN; k++)
            apb_write(HOST_IMEM, k, prog[k], 1'b0);
        run_model();
        apb_write(HOST_CTRL, 0, 32'd1, 1'b0);
        repeat (RUN_CYCLES) @(posedge SYS_clk);
        #1;
        apb_write(HOST_CTRL, 0, 32'd0, 1'b0);
        for (k = 1; k < 8; k++)
        begin
            apb_read(HOST_REGS, k, 1'b0, got);
            check_word($sformatf("r%0d", k), got, mreg[k]);
        end
        if (kind == 1)
        begin
            for (k = 0; k < 16; k++)
            begin
                apb_read(HOST_DMEM, k, 1'b0, got);
                check_word($sformatf("dmem[%0d]", k), got, mdmem[k]);
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h89ac));
        SYS_reset    = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        for (int r = 0; r < 8; r++)
            mreg[r] = '0;
        repeat (4) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;

        halted_access();
        finish_test("test 1 host access while halted");
        busy_access();
        finish_test("test 2 host access while running");
        repeat (N_PROGS) run_program(0);
        finish_test("test 3 dependent alu programs");
        repeat (N_PROGS) run_program(1);
        finish_test("test 4 load and store programs");
        repeat (N_PROGS) run_program(2);
        finish_test("test 5 branch programs");

        $display("all tests: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the cpu_system testbench with verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f cpu_system.f --top-module cpu_system_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vcpu_system_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Everything OK$"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

// ==== verilog/apb_host_port.sv ====
////////////////////////////////////////////////////////////
// apb slave for the host: run bit, memory load and readback
// setup cycle then two access cycles, pready in the second
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module apb_host_port
    import cpu_pkg::*;
#(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8
)
(
    input  logic        SYS_clk,
    input  logic        SYS_reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  word_t       pwdata,
    output word_t       prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        run,
    output host_req_t   host_req,
    input  word_t       imem_rdata,
    input  word_t       dmem_rdata,
    input  word_t       reg_rdata
);
    logic [1:0]  region;
    logic [11:0] idx;
    logic        access;                // first access cycle, all effects land here
    logic        err;
    word_t       rd_mux;

    assign region = paddr[15:14];
    assign idx    = paddr[13:2];
    assign access = psel && penable && !pready;

    always_comb
    begin
        case (region)
            HOST_CTRL: err = 1'b0;
            HOST_IMEM: err = run || (|(idx >> IMEM_AW));   // busy or past end of memory
            HOST_DMEM: err = run || (|(idx >> DMEM_AW));
            default:   err = run || pwrite;                 // regs are read only
        endcase

        case (region)
            HOST_CTRL: rd_mux = {31'b0, run};
            HOST_IMEM: rd_mux = imem_rdata;
            HOST_DMEM: rd_mux = dmem_rdata;
            default:   rd_mux = reg_rdata;
        endcase
    end

    assign host_req = '{
        imem_we: access && pwrite && !err && (region == HOST_IMEM),
        dmem_we: access && pwrite && !err && (region == HOST_DMEM),
        addr:    idx,
        wdata:   pwdata
    };

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            run     <= 1'b0;
        end
        else
        begin
            pready  <= access;          // high for one cycle, ends the transfer
            pslverr <= access && err;
            if (access && pwrite && region == HOST_CTRL)
                run <= pwdata[0];
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (access)
            prdata <= err ? '0 : rd_mux;
    end

    a_penable_needs_psel: assert property (
        @(posedge SYS_clk) disable iff (SYS_reset) $rose(penable) |-> psel
    ) else $error("penable rose without psel");

endmodule

// ==== verilog/cpu_system.sv ====
////////////////////////////////////////////////////////////
// top of the five stage cpu, wires the pipeline stages,
// the hazard unit and the apb host port together
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_system
    import cpu_pkg::*;
#(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8
)
(
    input  logic        SYS_clk,
    input  logic        SYS_reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  word_t       pwdata,
    output word_t       prdata,
    output logic        pready,
    output logic        pslverr
);
    logic      run;
    host_req_t host_req;
    word_t     imem_rdata;
    word_t     dmem_rdata;
    word_t     reg_rdata;
    logic      stall;
    logic      fwd_rs;
    logic      fwd_rt;
    logic      branch_taken;
    word_t     branch_target;
    word_t     fd_instr;
    word_t     fd_pc;
    reg_idx_t  rs_idx;
    reg_idx_t  rt_idx;
    logic      uses_rs;
    logic      uses_rt;
    dec_ex_t   dx;
    ex_mem_t   xm;
    wb_t       wb;

    apb_host_port #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_host (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .run        (run),
        .host_req   (host_req),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata),
        .reg_rdata  (reg_rdata)
    );

    instr_fetch #(.IMEM_AW(IMEM_AW)) u_fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .run           (run),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .host_req      (host_req),
        .imem_rdata    (imem_rdata),
        .fd_instr      (fd_instr),
        .fd_pc         (fd_pc)
    );

    decode_stage u_decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .run           (run),
        .stall         (stall),
        .fd_instr      (fd_instr),
        .fd_pc         (fd_pc),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt),
        .mem_fwd       (xm.result),         // alu result waiting in memory stage
        .wb            (wb),
        .host_req      (host_req),
        .reg_rdata     (reg_rdata),
        .rs_idx        (rs_idx),
        .rt_idx        (rt_idx),
        .uses_rs       (uses_rs),
        .uses_rt       (uses_rt),
        .dx            (dx),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    hazard_unit u_hazard (
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .uses_rs (uses_rs),
        .uses_rt (uses_rt),
        .dx      (dx),
        .xm      (xm),
        .stall   (stall),
        .fwd_rs  (fwd_rs),
        .fwd_rt  (fwd_rt)
    );

    execute_stage u_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .run       (run),
        .dx        (dx),
        .xm        (xm)
    );

    mem_wb_stage #(.DMEM_AW(DMEM_AW)) u_mem_wb (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .xm         (xm),
        .host_req   (host_req),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

endmodule

// ==== verilog/execute_stage.sv ====
////////////////////////////////////////////////////////////
// execute stage: alu with immediate select, loads the
// execute/memory register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  logic    run,
    input  dec_ex_t dx,
    output ex_mem_t xm
);
    word_t op_b;
    word_t alu_res;

    assign op_b = dx.use_imm ? dx.imm : dx.rt_val;

    always_comb
    begin
        case (dx.alu_op)
            ALU_ADD: alu_res = dx.rs_val + op_b;
            ALU_SUB: alu_res = dx.rs_val - op_b;
            ALU_AND: alu_res = dx.rs_val & op_b;
            ALU_OR:  alu_res = dx.rs_val | op_b;
            ALU_SLT: alu_res = {31'b0, $signed(dx.rs_val) < $signed(op_b)};
            default: alu_res = dx.rs_val + op_b;
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !run)
        begin
            xm.reg_we    <= 1'b0;
            xm.mem_read  <= 1'b0;
            xm.mem_write <= 1'b0;
        end
        else
        begin
            xm.reg_we    <= dx.reg_we;
            xm.mem_read  <= dx.mem_read;
            xm.mem_write <= dx.mem_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        xm.result     <= alu_res;       // also the load/store address
        xm.store_data <= dx.rt_val;
        xm.dest       <= dx.dest;
    end

endmodule

// ==== verilog/hazard_unit.sv ====
////////////////////////////////////////////////////////////
// stall and forward decision for the instruction in decode
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hazard_unit
    import cpu_pkg::*;
(
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     uses_rs,
    input  logic     uses_rt,
    input  dec_ex_t  dx,
    input  ex_mem_t  xm,
    output logic     stall,
    output logic     fwd_rs,
    output logic     fwd_rt
);
    logic ex_rs;
    logic ex_rt;
    logic mem_rs;
    logic mem_rt;
    logic stall_rs;
    logic stall_rt;

    function automatic logic src_hit(reg_idx_t src, logic used, reg_idx_t dst, logic we);
        return used && we && (src != '0) && (src == dst);
    endfunction

    assign ex_rs  = src_hit(rs_idx, uses_rs, dx.dest, dx.reg_we);
    assign ex_rt  = src_hit(rt_idx, uses_rt, dx.dest, dx.reg_we);
    assign mem_rs = src_hit(rs_idx, uses_rs, xm.dest, xm.reg_we);
    assign mem_rt = src_hit(rt_idx, uses_rt, xm.dest, xm.reg_we);

    // result in execute not ready yet, load data not ready until write-back
    assign stall_rs = ex_rs || (mem_rs && xm.mem_read);
    assign stall_rt = ex_rt || (mem_rt && xm.mem_read);
    assign stall    = stall_rs || stall_rt;

    // younger producer in execute wins over the memory stage
    assign fwd_rs = mem_rs && !xm.mem_read && !ex_rs;
    assign fwd_rt = mem_rt && !xm.mem_read && !ex_rt;

    always_comb
    begin
        a_fwd_or_stall: assert (!(fwd_rs && stall_rs) && !(fwd_rt && stall_rt))
            else $error("operand both forwarded and stalled");
    end

endmodule

// ==== verilog/instr_fetch.sv ====
////////////////////////////////////////////////////////////
// pc, instruction memory and the fetch/decode register
// host owns the memory port while the core is halted
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_fetch
    import cpu_pkg::*;
#(
    parameter int IMEM_AW = 8
)
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  logic      run,
    input  logic      stall,
    input  logic      branch_taken,
    input  word_t     branch_target,
    input  host_req_t host_req,
    output word_t     imem_rdata,
    output word_t     fd_instr,
    output word_t     fd_pc
);
    word_t              imem [2**IMEM_AW];
    word_t              pc;
    logic [IMEM_AW-1:0] imem_addr;

    assign imem_addr  = run ? pc[IMEM_AW+1:2] : host_req.addr[IMEM_AW-1:0];
    assign imem_rdata = imem[imem_addr];

    always_ff @(posedge SYS_clk)
    begin
        if (host_req.imem_we)
            imem[imem_addr] <= host_req.wdata;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !run)
            pc <= '0;                   // halted core restarts at 0
        else if (stall)
            pc <= pc;
        else if (branch_taken)
            pc <= branch_target;
        else
            pc <= pc + 32'd4;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !run || branch_taken)
            fd_instr <= '0;             // all zero word decodes as a bubble
        else if (!stall)
        begin
            fd_instr <= imem_rdata;
            fd_pc    <= pc;
        end
    end

endmodule

// ==== verilog/mem_wb_stage.sv ====
////////////////////////////////////////////////////////////
// data memory access and the write-back register
// host reaches the memory whenever the core is not using it
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_wb_stage
    import cpu_pkg::*;
#(
    parameter int DMEM_AW = 8
)
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  ex_mem_t   xm,
    input  host_req_t host_req,
    output word_t     dmem_rdata,
    output wb_t       wb
);
    word_t              dmem [2**DMEM_AW];
    logic [DMEM_AW-1:0] dmem_addr;
    logic               wb_we;
    logic               wb_load;
    reg_idx_t           wb_dest;
    word_t              wb_alu;
    word_t              wb_mem;

    assign dmem_addr  = (xm.mem_read || xm.mem_write) ? xm.result[DMEM_AW+1:2]
                                                     : host_req.addr[DMEM_AW-1:0];
    assign dmem_rdata = dmem[dmem_addr];

    always_ff @(posedge SYS_clk)
    begin
        if (xm.mem_write)
            dmem[dmem_addr] <= xm.store_data;
        else if (host_req.dmem_we)
            dmem[dmem_addr] <= host_req.wdata;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_we   <= 1'b0;
            wb_load <= 1'b0;
        end
        else
        begin
            wb_we   <= xm.reg_we;
            wb_load <= xm.mem_read;
        end
        wb_dest <= xm.dest;
        wb_alu  <= xm.result;
        wb_mem  <= dmem_rdata;
    end

    assign wb = '{we: wb_we, dest: wb_dest, data: wb_load ? wb_mem : wb_alu};

    a_no_read_and_write: assert property (
        @(posedge SYS_clk) disable iff (SYS_reset) !(xm.mem_read && xm.mem_write)
    ) else $error("memory stage holds both a load and a store");

endmodule
